// ==== hdl/key_decode.sv ====
// Frame-strobe edge detector and keycode-to-command decoder
`include "sprite_consts.svh"

module key_decode
(
    input  logic                Clk,
    input  logic                rst,
    input  logic                frameClk,
    input  logic [7:0]          keycode,
    output logic                frameTick,
    output sprite_pkg::moveCmdT cmd
);

    logic                frameClkDly;   // frameClk as sampled one clock earlier
    sprite_pkg::moveCmdT cmdNext;

    // Only the four movement keys map to a command
    always_comb
    begin
        case (keycode)
            `KEY_UP:    cmdNext = sprite_pkg::cmdUp;
            `KEY_DOWN:  cmdNext = sprite_pkg::cmdDown;
            `KEY_LEFT:  cmdNext = sprite_pkg::cmdLeft;
            `KEY_RIGHT: cmdNext = sprite_pkg::cmdRight;
            default:    cmdNext = sprite_pkg::cmdNone;
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            frameClkDly <= 1'b0;
            frameTick   <= 1'b0;
            cmd         <= sprite_pkg::cmdNone;
        end
        else
        begin
            frameClkDly <= frameClk;
            frameTick   <= frameClk & ~frameClkDly;    // One pulse per new frame
            cmd         <= cmdNext;                    // Lines up with frameTick
        end
    end

endmodule

// ==== hdl/sprite_address.sv ====
// Pixel hit test against the sprite rectangle and sprite-sheet address computation
`include "sprite_consts.svh"

module sprite_address
(
    input  logic [8:0]     pixelX,
    input  logic [8:0]     pixelY,
    sprite_state_if.render state,
    output logic           isObj,
    output logic [15:0]    objAddress
);

    localparam logic [15:0] spriteW   = `SPRITE_WIDTH;
    localparam logic [15:0] poseWords = `SPRITE_WIDTH * `SPRITE_HEIGHT;  // Words per pose

    logic [`POS_BITS-1:0] pixX;        // Pixel widened to position width
    logic [`POS_BITS-1:0] pixY;
    logic                 hitX;
    logic                 hitY;
    logic [`POS_BITS-1:0] dx;          // Distance from the sprite corner
    logic [`POS_BITS-1:0] dy;
    logic [1:0]           poseStep;    // Pose within the direction group
    logic [3:0]           pose;
    logic [15:0]          offset;

    assign pixX = {{(`POS_BITS - 9){1'b0}}, pixelX};
    assign pixY = {{(`POS_BITS - 9){1'b0}}, pixelY};

    // Half-open rectangle, the corner pixel belongs to the sprite
    assign hitX  = (pixX >= state.xPos) && (pixX < state.xPos + `SPRITE_WIDTH);
    assign hitY  = (pixY >= state.yPos) && (pixY < state.yPos + `SPRITE_HEIGHT);
    assign isObj = hitX && hitY;

    assign dx = pixX - state.xPos;
    assign dy = pixY - state.yPos;

    assign offset = 16'(dx) + 16'(dy) * spriteW;

    // Even steps stand, odd steps alternate between the two walk poses
    always_comb
    begin
        if (state.stepCount[0])
        begin
            poseStep = 2'd1 + {1'b0, state.stepCount[1]};
        end
        else
        begin
            poseStep = 2'd0;
        end
    end

    // Three poses per facing direction
    assign pose = 4'(state.facing) * 4'd3 + {2'b00, poseStep};

    always_comb
    begin
        if (isObj)
        begin
            objAddress = offset + 16'(pose) * poseWords;
        end
        else
        begin
            objAddress = 16'd0;    // Background pixel
        end
    end

endmodule

// ==== hdl/sprite_motion.sv ====
// Sprite position, facing and walk-step update with playfield boundary blocking
`include "sprite_consts.svh"

module sprite_motion
(
    input  logic                Clk,
    input  logic                rst,
    input  logic                frameTick,
    input  sprite_pkg::moveCmdT cmd,
    sprite_state_if.motion      state
);

    // Start corner is the start centre minus half the sprite
    localparam logic [`POS_BITS-1:0] xStart = `START_X_CENTER - `SPRITE_WIDTH / 2;
    localparam logic [`POS_BITS-1:0] yStart = `START_Y_CENTER - `SPRITE_HEIGHT / 2;
    localparam logic [`POS_BITS-1:0] stepX  = `STEP_X;
    localparam logic [`POS_BITS-1:0] stepY  = `STEP_Y;

    logic                 isMove;       // Frame tick carrying a direction
    logic                 blocked;      // Move would leave the playfield
    sprite_pkg::dirT      cmdDir;
    sprite_pkg::dirT      facingNext;
    logic [`POS_BITS-1:0] xNext;
    logic [`POS_BITS-1:0] yNext;
    logic [1:0]           stepNext;

    assign isMove = frameTick && (cmd != sprite_pkg::cmdNone);

    // Direction requested by the command and whether the bound stops it
    always_comb
    begin
        cmdDir  = state.facing;
        blocked = 1'b0;
        case (cmd)
            sprite_pkg::cmdUp:
            begin
                cmdDir  = sprite_pkg::dirUp;
                blocked = (state.yPos <= `FIELD_Y_MIN);
            end
            sprite_pkg::cmdDown:
            begin
                cmdDir  = sprite_pkg::dirDown;
                blocked = (state.yPos + `SPRITE_HEIGHT >= `FIELD_Y_MAX);
            end
            sprite_pkg::cmdLeft:
            begin
                cmdDir  = sprite_pkg::dirLeft;
                blocked = (state.xPos <= `FIELD_X_MIN);
            end
            sprite_pkg::cmdRight:
            begin
                cmdDir  = sprite_pkg::dirRight;
                blocked = (state.xPos + `SPRITE_WIDTH >= `FIELD_X_MAX);
            end
            default:
            begin
                cmdDir  = state.facing;
                blocked = 1'b1;
            end
        endcase
    end

    always_comb
    begin
        xNext      = state.xPos;
        yNext      = state.yPos;
        facingNext = state.facing;
        stepNext   = state.stepCount;
        if (isMove)
        begin
            facingNext = cmdDir;
            // Turning restarts the walk cycle, blocked moves still animate
            stepNext   = (cmdDir == state.facing) ? state.stepCount + 2'd1 : 2'd1;
            if (!blocked)
            begin
                case (cmdDir)
                    sprite_pkg::dirUp:    yNext = state.yPos - stepY;
                    sprite_pkg::dirDown:  yNext = state.yPos + stepY;
                    sprite_pkg::dirLeft:  xNext = state.xPos - stepX;
                    sprite_pkg::dirRight: xNext = state.xPos + stepX;
                    default:              xNext = state.xPos;
                endcase
            end
        end
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            state.xPos      <= xStart;
            state.yPos      <= yStart;
            state.facing    <= sprite_pkg::dirDown;
            state.stepCount <= 2'd0;
        end
        else
        begin
            state.xPos      <= xNext;
            state.yPos      <= yNext;
            state.facing    <= facingNext;
            state.stepCount <= stepNext;
        end
    end

endmodule

// ==== hdl/sprite_pkg.sv ====
// Facing-direction and movement-command enum types
package sprite_pkg;

    // Facing direction
    // The encoding is also the pose-group index in the sprite sheet
    typedef enum logic [1:0]
    {
        dirDown  = 2'd0,
        dirLeft  = 2'd1,
        dirUp    = 2'd2,
        dirRight = 2'd3
    } dirT;

    // Movement command decoded from the keycode
    typedef enum logic [2:0]
    {
        cmdNone  = 3'd0,    // No key or an unmapped key
        cmdUp    = 3'd1,
        cmdDown  = 3'd2,
        cmdLeft  = 3'd3,
        cmdRight = 3'd4
    } moveCmdT;

endpackage

// ==== hdl/sprite_player.sv ====
// Player sprite top level joining key decode, motion and address blocks
module sprite_player
(
    input  logic        Clk,
    input  logic        rst,
    input  logic        frameClk,      // New frame on rising edge, about 60 Hz
    input  logic [7:0]  keycode,
    input  logic [8:0]  pixelX,
    input  logic [8:0]  pixelY,
    output logic        isObj,
    output logic [15:0] objAddress
);

    logic                frameTick;
    sprite_pkg::moveCmdT cmd;

    // Position, facing and step count from motion to address
    sprite_state_if spriteState ();

    key_decode decode0
    (
        .Clk       (Clk),
        .rst       (rst),
        .frameClk  (frameClk),
        .keycode   (keycode),
        .frameTick (frameTick),
        .cmd       (cmd)
    );

    sprite_motion motion0
    (
        .Clk       (Clk),
        .rst       (rst),
        .frameTick (frameTick),
        .cmd       (cmd),
        .state     (spriteState.motion)
    );

    sprite_address address0
    (
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .state      (spriteState.render),
        .isObj      (isObj),
        .objAddress (objAddress)
    );

endmodule

// ==== hdl/sprite_state_if.sv ====
// Sprite state interface with motion and render modports
`include "sprite_consts.svh"

interface sprite_state_if;

    logic [`POS_BITS-1:0] xPos;        // Top-left corner, X
    logic [`POS_BITS-1:0] yPos;        // Top-left corner, Y
    sprite_pkg::dirT      facing;
    logic [1:0]           stepCount;   // Walk step counter, selects the pose

    // Driven by the motion block
    modport motion
    (
        output xPos,
        output yPos,
        output facing,
        output stepCount
    );

    // Read by the address block
    modport render
    (
        input xPos,
        input yPos,
        input facing,
        input stepCount
    );

endinterface

// ==== include/sprite_consts.svh ====
// Sprite size, start centre, playfield bounds, step size and keycode macros
`ifndef SPRITE_CONSTS_SVH
`define SPRITE_CONSTS_SVH

// Character size in pixels
`define SPRITE_WIDTH    40
`define SPRITE_HEIGHT   64

// Start position, centre of the playfield
`define START_X_CENTER  160
`define START_Y_CENTER  120

// Playfield bounds, inclusive
`define FIELD_X_MIN     0
`define FIELD_X_MAX     319
`define FIELD_Y_MIN     0
`define FIELD_Y_MAX     239

`define STEP_X          1       // Pixels per frame on X
`define STEP_Y          1       // Pixels per frame on Y

// USB HID usage codes for W, S, A and D
`define KEY_UP          26
`define KEY_DOWN        22
`define KEY_LEFT        4
`define KEY_RIGHT       7

`define POS_BITS        10      // Width of the sprite position registers

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Builds the sprite_player testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module sprite_player_tb -f sprite_player.f \
    --Mdir obj_dir -o sim_sprite_player
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_sprite_player > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== sprite_player.f ====
+incdir+include
hdl/sprite_pkg.sv
hdl/sprite_state_if.sv
hdl/key_decode.sv
hdl/sprite_motion.sv
hdl/sprite_address.sv
hdl/sprite_player.sv
test/sprite_player_asserts.sv
test/sprite_player_tb.sv

// ==== test/sprite_input.txt ====
# name keycode frames pixelX pixelY isObj objAddress, all decimal
# Steps run in order and the sprite state carries over from one step to the next
reset_hit        0    0  140   88  1      0
reset_miss       0    0  139   88  0      0
right_one        7    1  141   88  1  25600
right_old_corner 0    0  140   88  0      0
down_three      22    3  150  100  1   5489
left_to_edge     4  141    0   91  1  10240
left_blocked     4    2    5   95  1  12965
left_edge_miss   0    0   40   91  0      0
unknown_key      0    5    0   91  1  12800
up_turn         26    1   10  100  1  18330

// ==== test/sprite_player_asserts.sv ====
// Concurrent assertions on sprite state bounds, update timing and address range
`include "sprite_consts.svh"

module sprite_player_asserts
(
    input logic                 Clk,
    input logic                 rst,
    input logic                 frameTick,
    input logic [`POS_BITS-1:0] xPos,
    input logic [`POS_BITS-1:0] yPos,
    input logic [1:0]           facing,
    input logic [1:0]           stepCount,
    input logic                 isObj,
    input logic [15:0]          objAddress
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int sheetWords = 12 * `SPRITE_WIDTH * `SPRITE_HEIGHT;   // Twelve poses

    // Whole sprite inside the playfield, a wrap below zero fails too
    xInField: assert property (@(posedge Clk) disable iff (rst)
        int'(xPos) >= `FIELD_X_MIN && int'(xPos) + `SPRITE_WIDTH <= `FIELD_X_MAX)
        else $error("Sprite X position %0d is outside the playfield", xPos);

    yInField: assert property (@(posedge Clk) disable iff (rst)
        int'(yPos) >= `FIELD_Y_MIN && int'(yPos) + `SPRITE_HEIGHT <= `FIELD_Y_MAX)
        else $error("Sprite Y position %0d is outside the playfield", yPos);

    // State moves only at the edge that ends a frame tick
    heldBetweenTicks: assert property (@(posedge Clk) disable iff (rst)
        !$past(frameTick) |-> $stable({xPos, yPos, facing, stepCount}))
        else $error("Sprite state changed without a frame tick");

    addrInSheet: assert property (@(posedge Clk) disable iff (rst)
        isObj |-> int'(objAddress) < sheetWords)
        else $error("Sprite address %0d is beyond the sprite sheet", objAddress);

endmodule

bind sprite_player sprite_player_asserts asserts0
(
    .Clk        (Clk),
    .rst        (rst),
    .frameTick  (frameTick),
    .xPos       (spriteState.xPos),
    .yPos       (spriteState.yPos),
    .facing     (spriteState.facing),
    .stepCount  (spriteState.stepCount),
    .isObj      (isObj),
    .objAddress (objAddress)
);

// ==== test/sprite_player_tb.sv ====
// Testbench for sprite_player with clock, reset, file stimulus, output checks and summary
`include "sprite_consts.svh"

module sprite_player_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int maxWait   = 8;                   // Longest single wait in clocks
    localparam int maxFrames = `FIELD_X_MAX + 1;    // Enough frames to cross the field

    logic        Clk;
    logic        rst;
    logic        frameClk;
    logic [7:0]  keycode;
    logic [8:0]  pixelX;
    logic [8:0]  pixelY;
    logic        isObj;
    logic [15:0] objAddress;
    int          errors;
    int          checks;

    sprite_player dut0
    (
        .Clk        (Clk),
        .rst        (rst),
        .frameClk   (frameClk),
        .keycode    (keycode),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .isObj      (isObj),
        .objAddress (objAddress)
    );

    always #4 Clk = ~Clk;    // 8 ns period

    // Counted wait on rising edges, capped by the timeout
    task automatic waitClocks(input int n);
        int count;
        count = 0;
        while (count < n && count < maxWait)
        begin
            @(posedge Clk);
            count++;
        end
        if (count < n)
        begin
            $display("Wait for %0d clocks is longer than the %0d clock timeout", n, maxWait);
            errors++;
        end
    endtask

    // One file step: key and frame pulses, then a pixel probe and both output checks
    task automatic runStep(input logic [255:0] name, input int key, input int frames,
                           input int px, input int py, input int expHit, input int expAddr);
        int i;
        i = 0;
        keycode <= 8'(key);
        if (frames > maxFrames)
        begin
            $display("Step %0s asks for %0d frames, more than the limit", name, frames);
            errors++;
        end
        while (i < frames && i < maxFrames)
        begin
            frameClk <= 1'b1;
            waitClocks(4);
            frameClk <= 1'b0;
            waitClocks(4);
            i++;
        end
        waitClocks(3);
        pixelX <= 9'(px);
        pixelY <= 9'(py);
        @(negedge Clk);    // Outputs are combinational, sampled mid-cycle
        checks++;
        if (isObj !== 1'(expHit))
        begin
            $display("FAILED %0s isObj expected %0d actual %0d", name, expHit, isObj);
            errors++;
        end
        if (objAddress !== 16'(expAddr))
        begin
            $display("FAILED %0s objAddress expected %0d actual %0d", name, expAddr, objAddress);
            errors++;
        end
        waitClocks(1);
    endtask

    initial
    begin
        int           fd;
        int           fields;
        string        line;
        logic [255:0] name;
        int           key;
        int           frames;
        int           px;
        int           py;
        int           expHit;
        int           expAddr;
        Clk      = 1'b0;
        rst      = 1'b1;
        frameClk = 1'b0;
        keycode  = 8'd0;
        pixelX   = 9'd0;
        pixelY   = 9'd0;
        errors   = 0;
        checks   = 0;
        waitClocks(2);
        rst <= 1'b0;
        fd = $fopen("test/sprite_input.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the stimulus file test/sprite_input.txt");
            errors++;
        end
        else
        begin
            // Comment and blank lines do not give all seven fields
            while ($fgets(line, fd) != 0)
            begin
                fields = $sscanf(line, "%s %d %d %d %d %d %d",
                                 name, key, frames, px, py, expHit, expAddr);
                if (fields == 7)
                    runStep(name, key, frames, px, py, expHit, expAddr);
            end
            $fclose(fd);
        end
        if (checks == 0)
        begin
            $display("No test steps were read from the stimulus file");
            errors++;
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // Hard stop if the run hangs
    initial
    begin
        #1ms;
        $display("Simulation timed out before the last test step finished");
        $display("Test failed");
        $finish;
    end

endmodule
